/* apb_pkg.sv */
package apb_pkg;

    // Bus word types.
    typedef logic [31:0] addr_t;   // Byte address.
    typedef logic [31:0] word_t;   // Data word.
    typedef logic [3:0]  strb_t;   // One enable per byte lane.

    // Bridge FSM, setup phase then access phase.
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } bridge_state_t;

    // Completer count and select field.
    localparam int NUM_SLAVES    = 4;
    localparam int SLAVE_SEL_LSB = 12;                  // Bits 13:12 pick the completer.
    localparam int SLAVE_SEL_W   = $clog2(NUM_SLAVES);

    // Anything above bit 13 set means outside the map.
    localparam addr_t MAP_BASE_MASK = 32'hffff_c000;

    // Register file geometry inside one completer.
    localparam int REGS_PER_SLAVE = 4;
    localparam int REG_IDX_LSB    = 2;                  // Word aligned, bits 3:2.
    localparam int REG_IDX_W      = $clog2(REGS_PER_SLAVE);

    // Read data for addresses that hit no completer.
    localparam word_t UNMAPPED_RDATA = 32'hdead_beef;

endpackage : apb_pkg

/* apb_bridge.sv */
`timescale 1ns/1ps

module apb_bridge import apb_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    // Generic bus from the requester.
    input  addr_t addr,
    input  word_t wdata,
    input  logic  ren,
    input  logic  wen,
    input  strb_t byte_en,
    output word_t rdata,
    output logic  busy,
    // APB requester side.
    output addr_t paddr,
    output logic  pwrite,
    output word_t pwdata,
    output strb_t pstrb,
    output logic  psel,
    output logic  penable,
    input  logic  pready,
    input  word_t prdata
);

    bridge_state_t state;
    bridge_state_t n_state;

    // Captured copy of the request.
    addr_t req_addr;
    word_t req_wdata;
    logic  req_wen;        // Low means read.
    strb_t req_strb;

    logic  req_pending;
    logic  capture;

    assign req_pending = ren || wen;
    // Take a new request when idle or as the current access finishes.
    assign capture = (state == IDLE) || ((state == ACCESS) && pready);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            state <= n_state;
        end
    end

    always_ff @(posedge CLK) begin
        if (capture) begin
            req_addr  <= addr;
            req_wdata <= wdata;
            req_wen   <= wen;
            req_strb  <= byte_en;
        end
    end

    always_comb begin
        n_state = state;
        case (state)
            IDLE: begin
                if (req_pending) begin
                    n_state = SETUP;
                end
            end
            SETUP: begin
                n_state = ACCESS;   // Setup always lasts one cycle.
            end
            ACCESS: begin
                if (pready) begin
                    n_state = req_pending ? SETUP : IDLE;
                end
            end
            default: begin
                n_state = IDLE;
            end
        endcase
    end

    // APB phase outputs, all zero while idle.
    always_comb begin
        paddr   = '0;
        pwrite  = 1'b0;
        pwdata  = '0;
        pstrb   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        if (state != IDLE) begin
            paddr   = req_addr;
            pwrite  = req_wen;
            pwdata  = req_wdata;
            pstrb   = req_strb;
            psel    = 1'b1;
            penable = (state == ACCESS);
        end
    end

    // Response to the requester.
    assign rdata = prdata;
    assign busy  = (state != ACCESS) || !pready;

    // Address and control hold from setup until the ready cycle.
    a_paddr_stable: assert property (@(posedge CLK) disable iff (!nRST)
        (psel && !(penable && pready)) |=> $stable(paddr) && $stable(pwrite) && $stable(pstrb))
        else $error("APB address or control changed inside a transfer");

    a_one_request: assert property (@(posedge CLK) disable iff (!nRST)
        !(ren && wen))
        else $error("ren and wen high together");

endmodule

/* apb_decoder.sv */
`timescale 1ns/1ps

module apb_decoder import apb_pkg::*; (
    input  addr_t                 paddr,
    input  logic                  psel,
    output logic [NUM_SLAVES-1:0] psel_vec,
    output logic                  unmapped
);

    logic                   mapped;
    logic [SLAVE_SEL_W-1:0] slave_idx;

    // Upper bits must all be clear.
    assign mapped    = (paddr & MAP_BASE_MASK) == '0;
    assign slave_idx = paddr[SLAVE_SEL_LSB +: SLAVE_SEL_W];

    // No completer answers, the response mux finishes the transfer.
    assign unmapped = psel && !mapped;

    always_comb begin
        psel_vec = '0;
        if (psel && mapped) begin
            psel_vec[slave_idx] = 1'b1;   // One-hot select.
        end
    end

endmodule

/* apb_regfile.sv */
`timescale 1ns/1ps

module apb_regfile import apb_pkg::*; #(
    parameter int WAIT_STATES = 0
) (
    input  logic  CLK,
    input  logic  nRST,
    input  logic  psel,
    input  logic  penable,
    input  logic  pwrite,
    input  addr_t paddr,
    input  word_t pwdata,
    input  strb_t pstrb,
    output logic  pready,
    output word_t prdata
);

    // Wide enough to count up to WAIT_STATES.
    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    word_t                regs [REGS_PER_SLAVE];
    logic [CNT_W-1:0]     wait_cnt;
    logic [REG_IDX_W-1:0] reg_idx;
    logic                 access;

    assign access  = psel && penable;
    assign reg_idx = paddr[REG_IDX_LSB +: REG_IDX_W];

    // Ready on access cycle WAIT_STATES + 1.
    assign pready = access && (wait_cnt == CNT_W'(WAIT_STATES));

    // Counts stalled access cycles, cleared between transfers.
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
        end else if (access && !pready) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < REGS_PER_SLAVE; i++) begin
                regs[i] <= '0;
            end
        end else if (pready && pwrite) begin
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (pstrb[b]) begin
                    regs[reg_idx][8*b +: 8] <= pwdata[8*b +: 8];   // Byte lane b.
                end
            end
        end
    end

    // Read data only in the ready cycle.
    assign prdata = (pready && !pwrite) ? regs[reg_idx] : '0;

    // Wait states hold to the cycle from the start of access.
    a_wait_states: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(access) |-> ##WAIT_STATES pready)
        else $error("pready not on access cycle %0d", WAIT_STATES + 1);

endmodule

/* apb_resp_mux.sv */
`timescale 1ns/1ps

module apb_resp_mux import apb_pkg::*; (
    input  logic [NUM_SLAVES-1:0] psel_vec,
    input  logic                  unmapped,
    input  logic                  penable,
    input  logic [NUM_SLAVES-1:0] pready_vec,
    input  word_t                 prdata_vec [NUM_SLAVES],
    output logic                  pready,
    output word_t                 prdata
);

    always_comb begin
        pready = 1'b0;
        prdata = '0;
        // Decoder guarantees a single select.
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (psel_vec[i]) begin
                pready = pready_vec[i];
                prdata = prdata_vec[i];
            end
        end
        // Unmapped access completes with no wait states.
        if (unmapped) begin
            pready = penable;
            prdata = UNMAPPED_RDATA;
        end
    end

endmodule

/* apb_subsystem.sv */
`timescale 1ns/1ps

module apb_subsystem import apb_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  addr_t addr,
    input  word_t wdata,
    input  logic  ren,
    input  logic  wen,
    input  strb_t byte_en,
    output word_t rdata,
    output logic  busy
);

    // Shared APB signals.
    addr_t paddr;
    logic  pwrite;
    word_t pwdata;
    strb_t pstrb;
    logic  psel;
    logic  penable;
    logic  pready;
    word_t prdata;

    // Per completer select and response.
    logic [NUM_SLAVES-1:0] psel_vec;
    logic                  unmapped;
    logic [NUM_SLAVES-1:0] pready_vec;
    word_t                 prdata_vec [NUM_SLAVES];

    apb_bridge i_apb_bridge (
        .CLK     (CLK),
        .nRST    (nRST),
        .addr    (addr),
        .wdata   (wdata),
        .ren     (ren),
        .wen     (wen),
        .byte_en (byte_en),
        .rdata   (rdata),
        .busy    (busy),
        .paddr   (paddr),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .psel    (psel),
        .penable (penable),
        .pready  (pready),
        .prdata  (prdata)
    );

    apb_decoder i_apb_decoder (
        .paddr    (paddr),
        .psel     (psel),
        .psel_vec (psel_vec),
        .unmapped (unmapped)
    );

    // Completer i stalls for i cycles.
    for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_slave
        apb_regfile #(
            .WAIT_STATES (i)
        ) i_apb_regfile (
            .CLK     (CLK),
            .nRST    (nRST),
            .psel    (psel_vec[i]),
            .penable (penable),
            .pwrite  (pwrite),
            .paddr   (paddr),
            .pwdata  (pwdata),
            .pstrb   (pstrb),
            .pready  (pready_vec[i]),
            .prdata  (prdata_vec[i])
        );
    end

    apb_resp_mux i_apb_resp_mux (
        .psel_vec   (psel_vec),
        .unmapped   (unmapped),
        .penable    (penable),
        .pready_vec (pready_vec),
        .prdata_vec (prdata_vec),
        .pready     (pready),
        .prdata     (prdata)
    );

endmodule

/* tb_apb_subsystem.sv */
`timescale 1ns/1ps

module tb_apb_subsystem import apb_pkg::*; ();

    localparam int          CLK_HALF     = 50;       // 100 ns period.
    localparam int          RESET_CYCLES = 5;
    localparam int          TRACE_COLS   = 6;        // op, addr, wdata, strb, rdata, latency.
    localparam int          TRACE_LINES  = 64;
    localparam int          BUSY_LIMIT   = 20;       // Longest legal transfer is 5 cycles.
    localparam logic [31:0] OP_END       = 32'hf;

    logic  CLK;
    logic  nRST;
    addr_t addr;
    word_t wdata;
    logic  ren;
    logic  wen;
    strb_t byte_en;
    word_t rdata;
    logic  busy;

    logic [31:0] trace_mem [TRACE_LINES*TRACE_COLS];

    int checks;
    int errors;

    apb_subsystem i_apb_subsystem (
        .CLK     (CLK),
        .nRST    (nRST),
        .addr    (addr),
        .wdata   (wdata),
        .ren     (ren),
        .wen     (wen),
        .byte_en (byte_en),
        .rdata   (rdata),
        .busy    (busy)
    );

    always #CLK_HALF CLK = ~CLK;

    task automatic check_word(input word_t got, input word_t exp, input addr_t where);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: read of 0x%08h gave 0x%08h, expected 0x%08h",
                     $time, where, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp, input addr_t where);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail at %0d ns: transfer to 0x%08h took %0d cycles, expected %0d",
                     $time, where, got, exp);
        end
    endtask

    // Puts one request on the generic bus.
    task automatic drive_request(input logic write, input addr_t a, input word_t d,
                                 input strb_t s);
        addr    = a;
        wdata   = d;
        byte_en = s;
        ren     = !write;
        wen     = write;
    endtask

    // Counts cycles on the falling edge until busy drops.
    task automatic wait_not_busy(output int cycles, output logic hung);
        cycles = 0;
        do begin
            @(posedge CLK);
            @(negedge CLK);
            cycles++;
        end while (busy && cycles < BUSY_LIMIT);
        hung = busy;
    endtask

    initial begin
        int          entry;
        int          base;
        int          cycles;
        int          errors_before;
        int          t_latency;
        logic [31:0] op;
        logic        hung;
        logic        found_end;
        addr_t       t_addr;
        word_t       t_wdata;
        strb_t       t_strb;
        word_t       t_rdata;

        CLK       = 1'b0;
        nRST      = 1'b0;
        addr      = '0;
        wdata     = '0;
        ren       = 1'b0;
        wen       = 1'b0;
        byte_en   = '0;
        checks    = 0;
        errors    = 0;
        hung      = 1'b0;
        found_end = 1'b0;
        entry     = 0;

        $readmemh("apb_trace.txt", trace_mem);

        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        while (!hung && !found_end && entry < TRACE_LINES) begin
            base = entry * TRACE_COLS;
            op   = trace_mem[base];
            if (op == OP_END) begin
                found_end = 1'b1;
            end else begin
                t_addr    = trace_mem[base + 1];
                t_wdata   = trace_mem[base + 2];
                t_strb    = trace_mem[base + 3][3:0];
                t_rdata   = trace_mem[base + 4];
                t_latency = int'(trace_mem[base + 5]);
                // Unchained entries start from an idle bridge.
                if (!op[1]) begin
                    ren = 1'b0;
                    wen = 1'b0;
                    @(negedge CLK);
                end
                drive_request(op[0], t_addr, t_wdata, t_strb);
                errors_before = errors;
                wait_not_busy(cycles, hung);
                if (hung) begin
                    $display("Transfer %0d to 0x%08h: busy never went low within %0d cycles",
                             entry, t_addr, BUSY_LIMIT);
                end else begin
                    if (!op[0]) begin
                        check_word(rdata, t_rdata, t_addr);   // Valid in busy-low cycle.
                    end
                    check_latency(cycles, t_latency, t_addr);
                    $display("Transfer %0d: %s 0x%08h in %0d cycles, %s", entry,
                             op[0] ? "write" : "read ", t_addr, cycles,
                             (errors == errors_before) ? "ok" : "mismatch");
                end
                entry++;
            end
        end

        ren = 1'b0;
        wen = 1'b0;
        if (!found_end && !hung) begin
            errors++;
            $display("Trace ran out after %0d lines without its end marker", entry);
        end

        $display("%0d transfers, %0d checks, %0d errors", entry, checks, errors);
        if (hung || errors != 0) begin
            $display("test failed");
        end else begin
            $display("test passed");
        end
        $finish;
    end

endmodule

/* apb_trace.txt */
// op addr wdata strb rdata latency, one transfer per line, all hex.
// op bit 0 is write, bit 1 chains onto the line before, f ends the trace.
0 00000000 00000000 0 00000000 2
2 00000004 00000000 0 00000000 2
2 00000008 00000000 0 00000000 2
2 0000000c 00000000 0 00000000 2
0 00001000 00000000 0 00000000 3
2 00001004 00000000 0 00000000 3
2 00001008 00000000 0 00000000 3
2 0000100c 00000000 0 00000000 3
2 00002000 00000000 0 00000000 4
2 00002004 00000000 0 00000000 4
2 00002008 00000000 0 00000000 4
2 0000200c 00000000 0 00000000 4
0 00003000 00000000 0 00000000 5
2 00003004 00000000 0 00000000 5
2 00003008 00000000 0 00000000 5
2 0000300c 00000000 0 00000000 5
1 00000000 11111111 f 00000000 2
3 00001000 22222222 f 00000000 3
3 00002004 33333333 f 00000000 4
3 0000300c 44444444 f 00000000 5
0 00000000 00000000 0 11111111 2
2 00001000 00000000 0 22222222 3
2 00002004 00000000 0 33333333 4
2 0000300c 00000000 0 44444444 5
2 00002000 00000000 0 00000000 4
1 00001000 aabbccdd 5 00000000 3
0 00001000 00000000 0 22bb22dd 3
0 00004000 00000000 0 deadbeef 2
3 00004000 55555555 f 00000000 2
2 00000000 00000000 0 11111111 2
2 8000300c 00000000 0 deadbeef 2
f 00000000 00000000 0 00000000 0

/* sources.f */
apb_pkg.sv
apb_bridge.sv
apb_decoder.sv
apb_regfile.sv
apb_resp_mux.sv
apb_subsystem.sv
tb_apb_subsystem.sv

/* Makefile */
# Verilator build and run for the APB subsystem testbench.

VERILATOR ?= verilator
TOP       ?= tb_apb_subsystem
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulation passes only if the log holds the pass line.
run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qx "test passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
